/* rp_analog.f */
design/rp_analog_pkg.sv
design/rp_reset_seq.sv
design/rp_adc_frontend.sv
design/rp_dac_mixer.sv
design/rp_dac_encoder.sv
design/rp_analog_top.sv
dv/rp_analog_tb.sv

/* Makefile */
# Verilator build, run and lint of the analog sample path

SIM        := verilator
TB_TOP     := rp_analog_tb
RTL_TOP    := rp_analog_top
FILELIST   := rp_analog.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := sim passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/rp_analog_tb.sv */
/*
 * analog sample path testbench
 * drives lock, ADC pins and generator/controller samples on the falling
 * edge, models the pipeline and checks every output with assertions
 */

`timescale 1ns/1ps

module rp_analog_tb;

  import rp_analog_pkg::*;

  localparam int HOLD_TMO = int'(RST_MAX) + 16;  // cycles to wait for release

  // one cycle of inputs as seen at a rising edge
  typedef struct {
    logic [N_CH-1:0][ADC_DW-1:0] raw;
    logic [N_CH-1:0][DAC_DW-1:0] asg;
    logic [N_CH-1:0][DAC_DW-1:0] pid;
    logic [1:0]                  loop_cfg;
    logic                        rstn;      // model reset seen by the registers
  } stage_t;

  logic      adc_clk = 1'b0;
  logic      arst_n_i;
  logic      pll_locked_i;
  logic[1:0] digital_loop_i;
  adc_raw_t  adc_dat_a_i, adc_dat_b_i;
  dac_smp_t  asg_dat_a_i, asg_dat_b_i, pid_dat_a_i, pid_dat_b_i;
  adc_smp_t  adc_dat_a_o, adc_dat_b_o;
  dac_code_t dac_dat_a_o, dac_dat_b_o;
  logic      adc_rstn_o;

  logic [N_CH-1:0][ADC_DW-1:0] exp_adc;  // expected acquire samples
  logic [N_CH-1:0][DAC_DW-1:0] exp_dac;  // expected DAC codes
  logic                        exp_rstn;

  stage_t smp_q[$];      // two-deep input history
  int     cyc;           // edges since reset release
  int     edge_cyc;      // edge that saw the lock rise
  logic   lock_prev;
  logic   edge_seen;
  int     seed;
  string  test_name;

  always #2 adc_clk = ~adc_clk;  // 4 ns

  rp_analog_top rp_analog_top_inst (.*);

  ////////////////////////////////////////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [ADC_DW-1:0] adc_from_raw(logic [ADC_DW-1:0] raw);
    return {raw[ADC_DW-1], ~raw[ADC_DW-2:0]};  // msb kept, rest inverted
  endfunction

  function automatic logic [DAC_DW-1:0] clamp_sum(logic [DAC_DW-1:0] a,
                                                  logic [DAC_DW-1:0] b);
    int sum;
    int hi;
    int lo;
    hi  = (1 << (DAC_DW - 1)) - 1;
    lo  = -(1 << (DAC_DW - 1));
    sum = int'(signed'(a)) + int'(signed'(b));
    if (sum > hi)
      sum = hi;
    else if (sum < lo)
      sum = lo;
    return sum[DAC_DW-1:0];
  endfunction

  function automatic logic [DAC_DW-1:0] dac_from_smp(logic [DAC_DW-1:0] v);
    return {v[DAC_DW-1], ~v[DAC_DW-2:0]};
  endfunction

  // sign plus the next 13 bits inverted
  function automatic logic [DAC_DW-1:0] dac_from_adc(logic [ADC_DW-1:0] v);
    return {v[ADC_DW-1], ~v[ADC_DW-2:ADC_DW-DAC_DW]};
  endfunction

  // reset seen before edge c, low 2..RST_MAX+1 edges after the lock edge
  function automatic logic rstn_at(int c, logic seen, int e);
    if (c == 0)
      return 1'b0;  // still the async reset value
    if (seen && c >= e + 2 && c < e + 2 + int'(RST_MAX))
      return 1'b0;
    return 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // pipeline model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge adc_clk) begin : ref_model
    stage_t            cur;
    stage_t            prv;
    logic [DAC_DW-1:0] sat_prv;  // mixer output before this edge
    logic [ADC_DW-1:0] adc_prv;  // front end output before this edge
    cur.raw      = {adc_dat_b_i, adc_dat_a_i};
    cur.asg      = {asg_dat_b_i, asg_dat_a_i};
    cur.pid      = {pid_dat_b_i, pid_dat_a_i};
    cur.loop_cfg = digital_loop_i;
    if (!arst_n_i) begin
      cyc       = 0;
      lock_prev = 1'b0;
      edge_seen = 1'b0;
      cur.rstn  = 1'b0;
    end else begin
      cur.rstn = rstn_at(cyc, edge_seen, edge_cyc);
      if (pll_locked_i && !lock_prev) begin
        edge_seen = 1'b1;
        edge_cyc  = cyc;
      end
      lock_prev = pll_locked_i;
      cyc++;
    end
    exp_rstn <= rstn_at(cyc, edge_seen, edge_cyc);  // for the next edge

    smp_q.push_front(cur);
    while (smp_q.size() > 2)
      void'(smp_q.pop_back());
    prv = smp_q[1];

    for (int ch = 0; ch < N_CH; ch++) begin
      sat_prv = prv.rstn ? clamp_sum(prv.asg[ch], prv.pid[ch]) : '0;
      adc_prv = prv.rstn ? adc_from_raw(prv.raw[ch]) : '0;  // loops never overlap
      if (!cur.rstn) begin
        exp_adc[ch] <= '0;
        exp_dac[ch] <= '0;
      end else begin
        exp_adc[ch] <= cur.loop_cfg[0] ? {2'b00, sat_prv} : adc_from_raw(cur.raw[ch]);
        exp_dac[ch] <= cur.loop_cfg[1] ? dac_from_adc(adc_prv) : dac_from_smp(sat_prv);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(string port, logic [15:0] exp, logic [15:0] act);
    $display("FAIL %s %s expected 0x%0h actual 0x%0h", test_name, port, exp, act);
    $display("sim failed");
    $fatal(1, "output mismatch");
  endtask

  task automatic report_timeout(string what);
    $display("timeout: %s", what);
    $display("sim failed");
    $fatal(1, "wait timed out");
  endtask

  rstn_chk: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    adc_rstn_o == exp_rstn)
    else report_mismatch("adc_rstn_o", 16'($sampled(exp_rstn)), 16'($sampled(adc_rstn_o)));
  adc_a_chk: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    adc_dat_a_o == exp_adc[0])
    else report_mismatch("adc_dat_a_o", $sampled(exp_adc[0]), $sampled(adc_dat_a_o));
  adc_b_chk: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    adc_dat_b_o == exp_adc[1])
    else report_mismatch("adc_dat_b_o", $sampled(exp_adc[1]), $sampled(adc_dat_b_o));
  dac_a_chk: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    dac_dat_a_o == exp_dac[0])
    else report_mismatch("dac_dat_a_o", 16'($sampled(exp_dac[0])), 16'($sampled(dac_dat_a_o)));
  dac_b_chk: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    dac_dat_b_o == exp_dac[1])
    else report_mismatch("dac_dat_b_o", 16'($sampled(exp_dac[1])), 16'($sampled(dac_dat_b_o)));

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_random_cycle();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    @(negedge adc_clk);
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    adc_dat_a_i = r0[15:0];
    adc_dat_b_i = r0[31:16];
    asg_dat_a_i = r1[13:0];   // full range, overflows happen often
    asg_dat_b_i = r1[29:16];
    pid_dat_a_i = r2[13:0];
    pid_dat_b_i = r2[29:16];
  endtask

  task automatic drive_sum(int a0, int p0, int a1, int p1);
    @(negedge adc_clk);
    asg_dat_a_i = a0[DAC_DW-1:0];
    pid_dat_a_i = p0[DAC_DW-1:0];
    asg_dat_b_i = a1[DAC_DW-1:0];
    pid_dat_b_i = p1[DAC_DW-1:0];
  endtask

  // at, just past and far past both limits
  task automatic drive_limits();
    drive_sum( 8191,     0, -8192,     0);
    drive_sum( 8191,     1, -8192,    -1);
    drive_sum( 8191,  8191, -8192, -8192);
    drive_sum( 4096,  4095, -4096, -4096);
    drive_sum( 4096,  4096, -4096, -4097);
    drive_sum(   -1,     1,     0, -8192);
  endtask

  task automatic wait_rstn(logic level, int limit, string what);
    int n;
    n = 0;
    while (adc_rstn_o !== level) begin
      if (n >= limit)
        report_timeout(what);
      drive_random_cycle();  // keep data moving through the hold
      n++;
    end
  endtask

  initial begin
    seed           = 15;
    test_name      = "reset";
    edge_cyc       = 0;
    arst_n_i       = 1'b0;
    pll_locked_i   = 1'b0;
    digital_loop_i = 2'b00;
    adc_dat_a_i    = '0;
    adc_dat_b_i    = '0;
    asg_dat_a_i    = '0;
    asg_dat_b_i    = '0;
    pid_dat_a_i    = '0;
    pid_dat_b_i    = '0;
    smp_q.push_front('{default: '0});
    smp_q.push_front('{default: '0});

    repeat (16) @(negedge adc_clk);
    arst_n_i = 1'b1;
    repeat (8) drive_random_cycle();

    test_name = "post_lock_reset";
    @(negedge adc_clk);
    pll_locked_i = 1'b1;
    wait_rstn(1'b0, 8, "sample reset did not go low after PLL lock");
    wait_rstn(1'b1, HOLD_TMO, "sample reset did not release after the hold");

    test_name = "adc_conversion_and_mix";
    repeat (200) drive_random_cycle();
    test_name = "saturating_mix";
    drive_limits();

    test_name = "adc_loop";
    @(negedge adc_clk);
    digital_loop_i = 2'b01;
    repeat (100) drive_random_cycle();
    drive_limits();
    @(negedge adc_clk);
    digital_loop_i = 2'b00;  // drain before the other loop
    repeat (4) drive_random_cycle();

    test_name = "dac_loop";
    @(negedge adc_clk);
    digital_loop_i = 2'b10;
    repeat (100) drive_random_cycle();

    test_name = "lock_loss";
    @(negedge adc_clk);
    digital_loop_i = 2'b00;
    pll_locked_i   = 1'b0;   // rstn must stay high
    repeat (40) drive_random_cycle();
    repeat (4) @(negedge adc_clk);

    $display("sim passed");
    $finish;
  end

endmodule

/* design/rp_analog_top.sv */
/*
 * analog sample path top
 * reset sequencer, ADC front end, DAC mixer and DAC encoder on adc_clk,
 * channel a and b ports packed into channel arrays
 */

`timescale 1ns/1ps

module rp_analog_top (
  input  logic                     adc_clk,         // sample clock
  input  logic                     arst_n_i,        // async reset, active low
  input  logic                     pll_locked_i,    // sampling PLL lock
  input  logic               [1:0] digital_loop_i,  // [0] adc loop, [1] dac loop
  // ADC pins
  input  rp_analog_pkg::adc_raw_t  adc_dat_a_i,
  input  rp_analog_pkg::adc_raw_t  adc_dat_b_i,
  // generator and controller samples
  input  rp_analog_pkg::dac_smp_t  asg_dat_a_i,
  input  rp_analog_pkg::dac_smp_t  asg_dat_b_i,
  input  rp_analog_pkg::dac_smp_t  pid_dat_a_i,
  input  rp_analog_pkg::dac_smp_t  pid_dat_b_i,
  // acquire samples
  output rp_analog_pkg::adc_smp_t  adc_dat_a_o,
  output rp_analog_pkg::adc_smp_t  adc_dat_b_o,
  // DAC pins
  output rp_analog_pkg::dac_code_t dac_dat_a_o,
  output rp_analog_pkg::dac_code_t dac_dat_b_o,
  output logic                     adc_rstn_o       // sample reset, active low
);

  import rp_analog_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // channel arrays, index 0 is channel a
  ////////////////////////////////////////////////////////////////////////////

  logic                 smp_rstn;
  loop_cfg_t            loop_cfg;
  adc_raw_t  [N_CH-1:0] adc_raw;
  dac_smp_t  [N_CH-1:0] asg_dat;
  dac_smp_t  [N_CH-1:0] pid_dat;
  adc_smp_t  [N_CH-1:0] adc_dat;   // front end to encoder and out
  dac_smp_t  [N_CH-1:0] dac_sat;   // mixer to encoder and front end loop
  dac_code_t [N_CH-1:0] dac_code;

  assign loop_cfg = loop_cfg_t'(digital_loop_i);
  assign adc_raw  = {adc_dat_b_i, adc_dat_a_i};
  assign asg_dat  = {asg_dat_b_i, asg_dat_a_i};
  assign pid_dat  = {pid_dat_b_i, pid_dat_a_i};

  assign adc_dat_a_o = adc_dat[0];
  assign adc_dat_b_o = adc_dat[1];
  assign dac_dat_a_o = dac_code[0];
  assign dac_dat_b_o = dac_code[1];
  assign adc_rstn_o  = smp_rstn;

  ////////////////////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////////////////////

  rp_reset_seq rp_reset_seq_inst (
    .adc_clk      (adc_clk     ),
    .arst_n_i     (arst_n_i    ),
    .pll_locked_i (pll_locked_i),
    .smp_rstn_o   (smp_rstn    )
  );

  // ADC pins to adc_dat, 1 cycle
  rp_adc_frontend rp_adc_frontend_inst (
    .adc_clk    (adc_clk ),
    .arst_n_i   (arst_n_i),
    .smp_rstn_i (smp_rstn),
    .adc_raw_i  (adc_raw ),
    .loop_cfg_i (loop_cfg),
    .dac_sat_i  (dac_sat ),  // adc loop source
    .adc_dat_o  (adc_dat )
  );

  // asg + pid, saturated, 1 cycle
  rp_dac_mixer rp_dac_mixer_inst (
    .adc_clk    (adc_clk ),
    .arst_n_i   (arst_n_i),
    .smp_rstn_i (smp_rstn),
    .asg_dat_i  (asg_dat ),
    .pid_dat_i  (pid_dat ),
    .dac_sat_o  (dac_sat )
  );

  // mix or adc loop to DAC code, 1 cycle
  rp_dac_encoder rp_dac_encoder_inst (
    .adc_clk    (adc_clk ),
    .arst_n_i   (arst_n_i),
    .smp_rstn_i (smp_rstn),
    .loop_cfg_i (loop_cfg),
    .dac_sat_i  (dac_sat ),
    .adc_dat_i  (adc_dat ),  // dac loop source
    .dac_code_o (dac_code)
  );

endmodule

/* design/rp_dac_encoder.sv */
/*
 * DAC encoder
 * converts the saturated two's complement value into the DAC offset
 * negative-slope code, or passes ADC data when the DAC loop is on
 */

`timescale 1ns/1ps

module rp_dac_encoder (
  input  logic                                            adc_clk,
  input  logic                                            arst_n_i,
  input  logic                                            smp_rstn_i,  // sync
  input  rp_analog_pkg::loop_cfg_t                        loop_cfg_i,
  input  rp_analog_pkg::dac_smp_t  [rp_analog_pkg::N_CH-1:0] dac_sat_i,
  input  rp_analog_pkg::adc_smp_t  [rp_analog_pkg::N_CH-1:0] adc_dat_i,
  output rp_analog_pkg::dac_code_t [rp_analog_pkg::N_CH-1:0] dac_code_o
);

  import rp_analog_pkg::*;

  dac_code_t [N_CH-1:0] code_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // code conversion and loop select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int ch = 0; ch < N_CH; ch++) begin
      if (loop_cfg_i.dac_loop) begin
        // adc sign, then the next DAC_DW-1 bits inverted
        // low ADC bits drop off
        code_nxt[ch] = {adc_dat_i[ch][ADC_DW-1],
                        ~adc_dat_i[ch][ADC_DW-2 -: DAC_DW-1]};
      end else begin
        code_nxt[ch] = {dac_sat_i[ch][DAC_DW-1],
                        ~dac_sat_i[ch][DAC_DW-2:0]};  // offset neg slope
      end
    end
  end

  // pin code register, 1 cycle
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i)
      dac_code_o <= '0;
    else if (!smp_rstn_i)
      dac_code_o <= '0;  // 0 during the post-lock hold
    else
      dac_code_o <= code_nxt;
  end

endmodule

/* design/rp_dac_mixer.sv */
/*
 * DAC mixer
 * adds the generator and controller samples per channel and saturates
 * the sum to the DAC width, registered
 */

`timescale 1ns/1ps

module rp_dac_mixer (
  input  logic                                           adc_clk,
  input  logic                                           arst_n_i,
  input  logic                                           smp_rstn_i,  // sync
  input  rp_analog_pkg::dac_smp_t [rp_analog_pkg::N_CH-1:0] asg_dat_i,  // generator
  input  rp_analog_pkg::dac_smp_t [rp_analog_pkg::N_CH-1:0] pid_dat_i,  // controller
  output rp_analog_pkg::dac_smp_t [rp_analog_pkg::N_CH-1:0] dac_sat_o
);

  import rp_analog_pkg::*;

  logic     [SUM_DW-1:0] dac_sum [N_CH];  // one guard bit above DAC_DW
  dac_smp_t [N_CH-1:0]   dac_nxt;         // clamped sum

  ////////////////////////////////////////////////////////////////////////////
  // sum and saturation
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int ch = 0; ch < N_CH; ch++) begin
      // sign-extend both operands by one bit
      dac_sum[ch] = {asg_dat_i[ch][DAC_DW-1], asg_dat_i[ch]}
                  + {pid_dat_i[ch][DAC_DW-1], pid_dat_i[ch]};

      // top two bits differ means overflow
      if (^dac_sum[ch][SUM_DW-1 -: 2]) begin
        // sign bit picks the limit, max positive or max negative
        dac_nxt[ch] = dac_smp_t'({dac_sum[ch][SUM_DW-1],
                                  {(DAC_DW-1){~dac_sum[ch][SUM_DW-1]}}});
      end else begin
        dac_nxt[ch] = dac_smp_t'(dac_sum[ch][DAC_DW-1:0]);  // fits, pass low bits
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i)
      dac_sat_o <= '0;
    else if (!smp_rstn_i)
      dac_sat_o <= '0;
    else
      dac_sat_o <= dac_nxt;  // 1 cycle from asg/pid
  end

endmodule

/* design/rp_adc_frontend.sv */
/*
 * ADC front end
 * converts the unsigned negative-slope ADC code into two's complement,
 * or takes the saturated DAC mix instead when the ADC loop is on
 */

`timescale 1ns/1ps

module rp_adc_frontend (
  input  logic                                            adc_clk,
  input  logic                                            arst_n_i,
  input  logic                                            smp_rstn_i,  // sync
  input  rp_analog_pkg::adc_raw_t  [rp_analog_pkg::N_CH-1:0] adc_raw_i,
  input  rp_analog_pkg::loop_cfg_t                        loop_cfg_i,
  input  rp_analog_pkg::dac_smp_t  [rp_analog_pkg::N_CH-1:0] dac_sat_i,
  output rp_analog_pkg::adc_smp_t  [rp_analog_pkg::N_CH-1:0] adc_dat_o
);

  import rp_analog_pkg::*;

  adc_smp_t [N_CH-1:0] adc_nxt;  // next sample per channel

  ////////////////////////////////////////////////////////////////////////////
  // code conversion and loop select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int ch = 0; ch < N_CH; ch++) begin
      if (loop_cfg_i.adc_loop)
        adc_nxt[ch] = adc_smp_t'({2'b00, dac_sat_i[ch]});  // zero-extended mix
      else
        adc_nxt[ch] = adc_smp_t'({adc_raw_i[ch][ADC_DW-1],   // keep msb
                                  ~adc_raw_i[ch][ADC_DW-2:0]}); // neg slope
    end
  end

  // one cycle, raw or mix to adc_dat
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i)
      adc_dat_o <= '0;
    else if (!smp_rstn_i)
      adc_dat_o <= '0;  // zero while the sample path is held
    else
      adc_dat_o <= adc_nxt;
  end

endmodule

/* design/rp_reset_seq.sv */
/*
 * sample path reset sequencer
 * holds the active-low sample reset for RST_MAX cycles once the sampling
 * PLL reports lock, counted from the sampled lock rising edge
 */

`timescale 1ns/1ps

module rp_reset_seq (
  input  logic adc_clk,       // sample clock
  input  logic arst_n_i,      // async reset, active low
  input  logic pll_locked_i,  // PLL lock status
  output logic smp_rstn_o     // sample path reset, active low
);

  import rp_analog_pkg::*;

  logic              pll_locked_r;  // lock, one cycle late
  logic              lock_rise;     // first cycle with lock high
  logic [RST_CW-1:0] rst_cnt;       // 0 = idle, 1..RST_MAX = holding
  logic              rst_busy;

  assign lock_rise = pll_locked_i & ~pll_locked_r;
  assign rst_busy  = |rst_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // lock edge and hold counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pll_locked_r <= 1'b0;
      rst_cnt      <= '0;
    end else begin
      pll_locked_r <= pll_locked_i;
      if (lock_rise || rst_busy) begin
        if (rst_cnt < RST_CW'(RST_MAX))
          rst_cnt <= rst_cnt + 1'b1;  // still holding
        else
          rst_cnt <= '0;              // hold done, back to idle
      end else if (!pll_locked_i) begin
        rst_cnt <= '0;                // idle while unlocked
      end
    end
  end

  // registered reset, low for every nonzero count
  // loss of lock alone leaves it high
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i)
      smp_rstn_o <= 1'b0;
    else
      smp_rstn_o <= ~rst_busy;
  end

endmodule

/* design/rp_analog_pkg.sv */
/*
 * analog sample path package
 * converter widths, per-channel sample types, loop configuration and
 * the post-lock reset hold length shared by the ADC/DAC path
 */

package rp_analog_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and counts
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned N_CH    = 2;           // analog channels, a and b
  localparam int unsigned ADC_DW  = 16;          // ADC sample width
  localparam int unsigned DAC_DW  = 14;          // DAC sample width
  localparam int unsigned SUM_DW  = DAC_DW + 1;  // mixer sum, one guard bit

  // sample path held in reset this many adc_clk cycles after lock
  localparam int unsigned RST_MAX = 64;
  localparam int unsigned RST_CW  = $clog2(RST_MAX + 1);  // 7 bits for 64

  ////////////////////////////////////////////////////////////////////////////
  // sample and pin types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic signed [ADC_DW-1:0] adc_smp_t;   // acquire, two's complement
  typedef logic signed [DAC_DW-1:0] dac_smp_t;   // generate, two's complement
  typedef logic        [ADC_DW-1:0] adc_raw_t;   // ADC pins, neg-slope code
  typedef logic        [DAC_DW-1:0] dac_code_t;  // DAC pins, offset neg-slope

  // digital loop select
  // bit 0 feeds the DAC mix back as ADC data
  // bit 1 feeds ADC data straight to the DAC
  typedef struct packed {
    logic dac_loop;  // msb, digital_loop[1]
    logic adc_loop;  // lsb, digital_loop[0]
  } loop_cfg_t;

endpackage
